// File: audio_alu_defines.svh
// fixed-point widths assume 16 fraction bits inside an 18-bit sample and a 48-bit accumulator
`ifndef AUDIO_ALU_DEFINES_SVH
`define AUDIO_ALU_DEFINES_SVH

// --------------------------------------------------
// number format
// --------------------------------------------------
`define AU_DATA_W        18
`define AU_FRAC_W        16
`define AU_ACC_W         48

// 1.0 in sample format
`define AU_ONE           18'sd65536

// --------------------------------------------------
// sizes and latencies
// --------------------------------------------------
// also the host credit count after reset
`define AU_QUEUE_DEPTH   2
`define AU_TAYLOR_TERMS  8
`define AU_DSP_LAT       2

`endif

// File: audio_alu_pkg.sv
// truncation keeps bits 33 down to 16 of a product and wraps without saturation
`include "audio_alu_defines.svh"

package audio_alu_pkg;

    typedef logic signed [`AU_DATA_W-1:0] sample_t;
    typedef logic signed [`AU_ACC_W-1:0]  acc_t;

    // function select
    typedef logic [1:0] func_t;
    localparam func_t FN_COS  = 2'd0;
    localparam func_t FN_SIN  = 2'd1;
    localparam func_t FN_EXP  = 2'd2;
    localparam func_t FN_FADE = 2'd3;

    // owner of a slice operation
    typedef logic owner_t;
    localparam owner_t OWN_TAYLOR = 1'b0;
    localparam owner_t OWN_FADE   = 1'b1;

    typedef enum logic [1:0] {T_IDLE, T_ISSUE, T_WAIT, T_DONE} taylor_state_t;
    typedef enum logic [2:0] {F_IDLE, F_MUL, F_MADD, F_WAIT, F_DONE} fade_state_t;

    function automatic sample_t to_sample(input acc_t p);
        return p[`AU_DATA_W+`AU_FRAC_W-1:`AU_FRAC_W];
    endfunction

    // sample aligned to the product scale
    function automatic acc_t widen(input sample_t v);
        return acc_t'(v) <<< `AU_FRAC_W;
    endfunction

endpackage

// File: cmd_queue.sv
// in-order queue where the head can block and a command sent while full is lost
`timescale 1ns/1ps
`include "audio_alu_defines.svh"

module cmd_queue
    import audio_alu_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_cmd_valid,
    input  func_t   i_cmd_func,
    input  sample_t i_cmd_xl,
    input  sample_t i_cmd_xr,
    input  sample_t i_cmd_gain,
    input  logic    i_taylor_busy,
    input  logic    i_fade_busy,
    output logic    o_taylor_start,
    output logic    o_fade_start,
    output func_t   o_func,
    output sample_t o_xl,
    output sample_t o_xr,
    output sample_t o_gain,
    output logic    o_credit
);

    localparam int PTR_W = $clog2(`AU_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`AU_QUEUE_DEPTH + 1);

    func_t            func_mem [`AU_QUEUE_DEPTH];
    sample_t          xl_mem   [`AU_QUEUE_DEPTH];
    sample_t          xr_mem   [`AU_QUEUE_DEPTH];
    sample_t          gain_mem [`AU_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;
    logic             head_fade;

    assign push = i_cmd_valid && (count != CNT_W'(`AU_QUEUE_DEPTH));

    // head goes out as soon as its own calculator is free
    assign head_fade = (func_mem[rd_ptr] == FN_FADE);
    assign pop       = (count != '0) && (head_fade ? !i_fade_busy : !i_taylor_busy);

    assign o_taylor_start = pop && !head_fade;
    assign o_fade_start   = pop && head_fade;
    assign o_credit       = pop;
    assign o_func         = func_mem[rd_ptr];
    assign o_xl           = xl_mem[rd_ptr];
    assign o_xr           = xr_mem[rd_ptr];
    assign o_gain         = gain_mem[rd_ptr];

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`AU_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`AU_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            func_mem[wr_ptr] <= i_cmd_func;
            xl_mem[wr_ptr]   <= i_cmd_xl;
            xr_mem[wr_ptr]   <= i_cmd_xr;
            gain_mem[wr_ptr] <= i_cmd_gain;
        end
    end

endmodule

// File: dsp_arbiter.sv
// requesters must hold request and operands until granted and grant is combinational
`timescale 1ns/1ps
`include "audio_alu_defines.svh"

module dsp_arbiter
    import audio_alu_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_req_taylor,
    input  logic    i_req_fade,
    input  sample_t i_t_al,
    input  sample_t i_t_bl,
    input  acc_t    i_t_cl,
    input  sample_t i_t_ar,
    input  sample_t i_t_br,
    input  acc_t    i_t_cr,
    input  logic    i_t_sub,
    input  sample_t i_f_al,
    input  sample_t i_f_bl,
    input  acc_t    i_f_cl,
    input  sample_t i_f_ar,
    input  sample_t i_f_br,
    input  acc_t    i_f_cr,
    input  logic    i_f_sub,
    output logic    o_gnt_taylor,
    output logic    o_gnt_fade,
    output sample_t o_al,
    output sample_t o_bl,
    output acc_t    o_cl,
    output sample_t o_ar,
    output sample_t o_br,
    output acc_t    o_cr,
    output logic    o_sub,
    output logic    o_issue,
    output logic    o_pv_taylor,
    output logic    o_pv_fade
);

    owner_t                 prio;
    owner_t                 issue_owner;
    logic [`AU_DSP_LAT-1:0] vld_sr;
    logic [`AU_DSP_LAT-1:0] own_sr;

    // --------------------------------------------------
    // round-robin grant
    // --------------------------------------------------
    assign o_gnt_taylor = i_req_taylor && (!i_req_fade || prio == OWN_TAYLOR);
    assign o_gnt_fade   = i_req_fade && (!i_req_taylor || prio == OWN_FADE);
    assign o_issue      = o_gnt_taylor || o_gnt_fade;
    assign issue_owner  = o_gnt_fade ? OWN_FADE : OWN_TAYLOR;

    assign o_al  = o_gnt_fade ? i_f_al  : i_t_al;
    assign o_bl  = o_gnt_fade ? i_f_bl  : i_t_bl;
    assign o_cl  = o_gnt_fade ? i_f_cl  : i_t_cl;
    assign o_ar  = o_gnt_fade ? i_f_ar  : i_t_ar;
    assign o_br  = o_gnt_fade ? i_f_br  : i_t_br;
    assign o_cr  = o_gnt_fade ? i_f_cr  : i_t_cr;
    assign o_sub = o_gnt_fade ? i_f_sub : i_t_sub;

    // owner tag follows the slice pipeline
    assign o_pv_taylor = vld_sr[`AU_DSP_LAT-1] && (own_sr[`AU_DSP_LAT-1] == OWN_TAYLOR);
    assign o_pv_fade   = vld_sr[`AU_DSP_LAT-1] && (own_sr[`AU_DSP_LAT-1] == OWN_FADE);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            prio   <= OWN_TAYLOR;
            vld_sr <= '0;
            own_sr <= '0;
        end else begin
            if (i_req_taylor && i_req_fade) begin
                prio <= o_gnt_taylor ? OWN_FADE : OWN_TAYLOR;
            end
            vld_sr <= {vld_sr[`AU_DSP_LAT-2:0], o_issue};
            own_sr <= {own_sr[`AU_DSP_LAT-2:0], issue_owner};
        end
    end

endmodule

// File: dsp_mac.sv
// fixed two-cycle latency and with i_sub set each lane gives c minus the product
`timescale 1ns/1ps

module dsp_mac
    import audio_alu_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_issue,
    input  logic    i_sub,
    input  sample_t i_al,
    input  sample_t i_bl,
    input  sample_t i_ar,
    input  sample_t i_br,
    input  acc_t    i_cl,
    input  acc_t    i_cr,
    output acc_t    o_pl,
    output acc_t    o_pr
);

    acc_t prod_l;
    acc_t prod_r;
    acc_t c_l_q;
    acc_t c_r_q;
    logic sub_q;
    logic issue_q;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= i_issue;
        end
    end

    always_ff @(posedge i_clk) begin
        // stage 1 multiply
        if (i_issue) begin
            prod_l <= acc_t'(i_al) * acc_t'(i_bl);
            prod_r <= acc_t'(i_ar) * acc_t'(i_br);
            c_l_q  <= i_cl;
            c_r_q  <= i_cr;
            sub_q  <= i_sub;
        end
        // stage 2 post-add
        if (issue_q) begin
            o_pl <= sub_q ? c_l_q - prod_l : c_l_q + prod_l;
            o_pr <= sub_q ? c_r_q - prod_r : c_r_q + prod_r;
        end
    end

endmodule

// File: taylor_coefs.sv
// coefficients hold only for inputs below 1.0 in magnitude and return zero for crossfade
`timescale 1ns/1ps
`include "audio_alu_defines.svh"

module taylor_coefs
    import audio_alu_pkg::*;
(
    input  func_t      i_func,
    input  logic [3:0] i_idx,
    output sample_t    o_coef,
    output sample_t    o_a0
);

    // c_n = f^(n)(a0) / n! in Q16, exp expanded around 0.5
    always_comb begin
        o_coef = '0;
        o_a0   = '0;
        case (i_func)
            FN_COS: begin
                case (i_idx)
                    4'd0: o_coef = `AU_ONE;
                    4'd2: o_coef = sample_t'(-32768);
                    4'd4: o_coef = sample_t'(2731);
                    4'd6: o_coef = sample_t'(-91);
                    default: o_coef = '0;
                endcase
            end
            FN_SIN: begin
                case (i_idx)
                    4'd1: o_coef = `AU_ONE;
                    4'd3: o_coef = sample_t'(-10923);
                    4'd5: o_coef = sample_t'(546);
                    4'd7: o_coef = sample_t'(-13);
                    default: o_coef = '0;
                endcase
            end
            FN_EXP: begin
                o_a0 = sample_t'(32768);
                case (i_idx)
                    4'd0: o_coef = sample_t'(108051);
                    4'd1: o_coef = sample_t'(108051);
                    4'd2: o_coef = sample_t'(54025);
                    4'd3: o_coef = sample_t'(18008);
                    4'd4: o_coef = sample_t'(4502);
                    4'd5: o_coef = sample_t'(900);
                    4'd6: o_coef = sample_t'(150);
                    4'd7: o_coef = sample_t'(21);
                    default: o_coef = '0;
                endcase
            end
            default: o_coef = '0;
        endcase
    end

endmodule

// File: taylor_calc.sv
// no range reduction so the input must stay below 1.0 and each of 8 slice ops waits on the last
`timescale 1ns/1ps
`include "audio_alu_defines.svh"

module taylor_calc
    import audio_alu_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_start,
    input  func_t   i_func,
    input  sample_t i_xl,
    input  sample_t i_xr,
    input  logic    i_gnt,
    input  logic    i_pv,
    input  acc_t    i_pl,
    input  acc_t    i_pr,
    output logic    o_busy,
    output logic    o_req,
    output sample_t o_al,
    output sample_t o_bl,
    output acc_t    o_cl,
    output sample_t o_ar,
    output sample_t o_br,
    output acc_t    o_cr,
    output logic    o_sub,
    output logic    o_done,
    output sample_t o_resl,
    output sample_t o_resr
);

    taylor_state_t state;
    func_t         func_q;
    sample_t       xl_q;
    sample_t       xr_q;
    sample_t       xal;
    sample_t       xar;
    sample_t       accl;
    sample_t       accr;
    sample_t       coef;
    sample_t       a0;
    logic [3:0]    step;
    logic [3:0]    coef_idx;
    logic          last_step;

    // step 0 reads c7 to seed the accumulator, step n reads c(7-n)
    assign coef_idx  = 4'(`AU_TAYLOR_TERMS - 1) - step;
    assign last_step = (step == 4'(`AU_TAYLOR_TERMS - 1));

    taylor_coefs i_taylor_coefs (
        .i_func (func_q),
        .i_idx  (coef_idx),
        .o_coef (coef),
        .o_a0   (a0)
    );

    // --------------------------------------------------
    // slice operands
    // --------------------------------------------------
    always_comb begin
        if (step == '0) begin
            // xa = x - a0 * 1.0
            o_al  = a0;
            o_bl  = `AU_ONE;
            o_cl  = widen(xl_q);
            o_ar  = a0;
            o_br  = `AU_ONE;
            o_cr  = widen(xr_q);
            o_sub = 1'b1;
        end else begin
            // horner step acc * xa + c(n)
            o_al  = accl;
            o_bl  = xal;
            o_cl  = widen(coef);
            o_ar  = accr;
            o_br  = xar;
            o_cr  = widen(coef);
            o_sub = 1'b0;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state <= T_IDLE;
            step  <= '0;
        end else begin
            case (state)
                T_IDLE: begin
                    if (i_start) begin
                        step  <= '0;
                        state <= T_ISSUE;
                    end
                end
                T_ISSUE: begin
                    if (i_gnt) begin
                        state <= T_WAIT;
                    end
                end
                T_WAIT: begin
                    if (i_pv) begin
                        if (last_step) begin
                            state <= T_DONE;
                        end else begin
                            step  <= step + 1'b1;
                            state <= T_ISSUE;
                        end
                    end
                end
                default: state <= T_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == T_IDLE && i_start) begin
            func_q <= i_func;
            xl_q   <= i_xl;
            xr_q   <= i_xr;
        end
        if (state == T_WAIT && i_pv) begin
            if (step == '0) begin
                xal  <= to_sample(i_pl);
                xar  <= to_sample(i_pr);
                accl <= coef;
                accr <= coef;
            end else begin
                accl <= to_sample(i_pl);
                accr <= to_sample(i_pr);
            end
        end
    end

    assign o_busy = (state != T_IDLE);
    assign o_req  = (state == T_ISSUE);
    assign o_done = (state == T_DONE);
    assign o_resl = accl;
    assign o_resr = accr;

endmodule

// File: crossfade_calc.sv
// left result is xr*(1-g)+xl*g and right is xl*(1-g)+xr*g so a zero gain swaps the lanes
`timescale 1ns/1ps
`include "audio_alu_defines.svh"

module crossfade_calc
    import audio_alu_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_start,
    input  sample_t i_xl,
    input  sample_t i_xr,
    input  sample_t i_gain,
    input  logic    i_gnt,
    input  logic    i_pv,
    input  acc_t    i_pl,
    input  acc_t    i_pr,
    output logic    o_busy,
    output logic    o_req,
    output sample_t o_al,
    output sample_t o_bl,
    output acc_t    o_cl,
    output sample_t o_ar,
    output sample_t o_br,
    output acc_t    o_cr,
    output logic    o_sub,
    output logic    o_done,
    output sample_t o_resl,
    output sample_t o_resr
);

    fade_state_t state;
    logic        second;
    sample_t     xl_q;
    sample_t     xr_q;
    sample_t     gain_q;
    sample_t     h;
    acc_t        pl_q;
    acc_t        pr_q;

    assign h = `AU_ONE - gain_q;

    // first op takes the opposite lane times h, second adds own lane times gain
    assign o_al  = (state == F_MADD) ? xl_q   : xr_q;
    assign o_bl  = (state == F_MADD) ? gain_q : h;
    assign o_cl  = (state == F_MADD) ? pl_q   : '0;
    assign o_ar  = (state == F_MADD) ? xr_q   : xl_q;
    assign o_br  = (state == F_MADD) ? gain_q : h;
    assign o_cr  = (state == F_MADD) ? pr_q   : '0;
    assign o_sub = 1'b0;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state  <= F_IDLE;
            second <= 1'b0;
        end else begin
            case (state)
                F_IDLE:  if (i_start) state <= F_MUL;
                F_MUL: begin
                    if (i_gnt) begin
                        second <= 1'b0;
                        state  <= F_WAIT;
                    end
                end
                F_MADD: begin
                    if (i_gnt) begin
                        second <= 1'b1;
                        state  <= F_WAIT;
                    end
                end
                F_WAIT:  if (i_pv) state <= second ? F_DONE : F_MADD;
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == F_IDLE && i_start) begin
            xl_q   <= i_xl;
            xr_q   <= i_xr;
            gain_q <= i_gain;
        end
        if (state == F_WAIT && i_pv) begin
            if (second) begin
                o_resl <= to_sample(i_pl);
                o_resr <= to_sample(i_pr);
            end else begin
                // full 48-bit products for the second add
                pl_q <= i_pl;
                pr_q <= i_pr;
            end
        end
    end

    assign o_busy = (state != F_IDLE);
    assign o_req  = (state == F_MUL) || (state == F_MADD);
    assign o_done = (state == F_DONE);

endmodule

// File: audio_alu_top.sv
// results have no back-pressure and may leave in a different order across the two calculators
`timescale 1ns/1ps

module audio_alu_top
    import audio_alu_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_cmd_valid,
    input  func_t   i_cmd_func,
    input  sample_t i_cmd_xl,
    input  sample_t i_cmd_xr,
    input  sample_t i_cmd_gain,
    output logic    o_credit,
    output logic    o_taylor_done,
    output sample_t o_taylor_l,
    output sample_t o_taylor_r,
    output logic    o_fade_done,
    output sample_t o_fade_l,
    output sample_t o_fade_r
);

    // dispatch
    logic    taylor_start, fade_start, taylor_busy, fade_busy;
    func_t   d_func;
    sample_t d_xl, d_xr, d_gain;

    // slice requests and operands
    logic    t_req, t_gnt, t_pv, t_sub;
    logic    f_req, f_gnt, f_pv, f_sub;
    sample_t t_al, t_bl, t_ar, t_br;
    sample_t f_al, f_bl, f_ar, f_br;
    acc_t    t_cl, t_cr, f_cl, f_cr;

    // shared slice
    logic    m_issue, m_sub;
    sample_t m_al, m_bl, m_ar, m_br;
    acc_t    m_cl, m_cr, m_pl, m_pr;

    cmd_queue i_cmd_queue (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_cmd_valid    (i_cmd_valid),
        .i_cmd_func     (i_cmd_func),
        .i_cmd_xl       (i_cmd_xl),
        .i_cmd_xr       (i_cmd_xr),
        .i_cmd_gain     (i_cmd_gain),
        .i_taylor_busy  (taylor_busy),
        .i_fade_busy    (fade_busy),
        .o_taylor_start (taylor_start),
        .o_fade_start   (fade_start),
        .o_func         (d_func),
        .o_xl           (d_xl),
        .o_xr           (d_xr),
        .o_gain         (d_gain),
        .o_credit       (o_credit)
    );

    taylor_calc i_taylor_calc (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_start (taylor_start),
        .i_func  (d_func),
        .i_xl    (d_xl),
        .i_xr    (d_xr),
        .i_gnt   (t_gnt),
        .i_pv    (t_pv),
        .i_pl    (m_pl),
        .i_pr    (m_pr),
        .o_busy  (taylor_busy),
        .o_req   (t_req),
        .o_al    (t_al),
        .o_bl    (t_bl),
        .o_cl    (t_cl),
        .o_ar    (t_ar),
        .o_br    (t_br),
        .o_cr    (t_cr),
        .o_sub   (t_sub),
        .o_done  (o_taylor_done),
        .o_resl  (o_taylor_l),
        .o_resr  (o_taylor_r)
    );

    crossfade_calc i_crossfade_calc (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_start (fade_start),
        .i_xl    (d_xl),
        .i_xr    (d_xr),
        .i_gain  (d_gain),
        .i_gnt   (f_gnt),
        .i_pv    (f_pv),
        .i_pl    (m_pl),
        .i_pr    (m_pr),
        .o_busy  (fade_busy),
        .o_req   (f_req),
        .o_al    (f_al),
        .o_bl    (f_bl),
        .o_cl    (f_cl),
        .o_ar    (f_ar),
        .o_br    (f_br),
        .o_cr    (f_cr),
        .o_sub   (f_sub),
        .o_done  (o_fade_done),
        .o_resl  (o_fade_l),
        .o_resr  (o_fade_r)
    );

    dsp_arbiter i_dsp_arbiter (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_req_taylor (t_req),
        .i_req_fade   (f_req),
        .i_t_al       (t_al),
        .i_t_bl       (t_bl),
        .i_t_cl       (t_cl),
        .i_t_ar       (t_ar),
        .i_t_br       (t_br),
        .i_t_cr       (t_cr),
        .i_t_sub      (t_sub),
        .i_f_al       (f_al),
        .i_f_bl       (f_bl),
        .i_f_cl       (f_cl),
        .i_f_ar       (f_ar),
        .i_f_br       (f_br),
        .i_f_cr       (f_cr),
        .i_f_sub      (f_sub),
        .o_gnt_taylor (t_gnt),
        .o_gnt_fade   (f_gnt),
        .o_al         (m_al),
        .o_bl         (m_bl),
        .o_cl         (m_cl),
        .o_ar         (m_ar),
        .o_br         (m_br),
        .o_cr         (m_cr),
        .o_sub        (m_sub),
        .o_issue      (m_issue),
        .o_pv_taylor  (t_pv),
        .o_pv_fade    (f_pv)
    );

    dsp_mac i_dsp_mac (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_issue (m_issue),
        .i_sub   (m_sub),
        .i_al    (m_al),
        .i_bl    (m_bl),
        .i_ar    (m_ar),
        .i_br    (m_br),
        .i_cl    (m_cl),
        .i_cr    (m_cr),
        .o_pl    (m_pl),
        .o_pr    (m_pr)
    );

endmodule

// File: tb_audio_alu.sv
// drives a fixed command table under credit flow control, and inputs must stay below 1.0
`timescale 1ns/1ps
`include "audio_alu_defines.svh"

module tb_audio_alu
    import audio_alu_pkg::*;
();

    localparam int NUM_TESTS       = 13;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + 200;
    localparam int DRAIN_CYCLES    = 150;

    logic                      i_clk;
    logic                      i_reset;
    logic                      i_cmd_valid;
    func_t                     i_cmd_func;
    logic signed [17:0]        i_cmd_xl;
    logic signed [17:0]        i_cmd_xr;
    logic signed [17:0]        i_cmd_gain;
    logic                      o_credit;
    logic                      o_taylor_done;
    logic signed [17:0]        o_taylor_l;
    logic signed [17:0]        o_taylor_r;
    logic                      o_fade_done;
    logic signed [17:0]        o_fade_l;
    logic signed [17:0]        o_fade_r;

    // --------------------------------------------------
    // stimulus table and expected results
    // --------------------------------------------------
    // mode 0 random gap, 1 wait until idle, 2 send right behind the last command
    string              t_name  [NUM_TESTS];
    func_t              t_func  [NUM_TESTS];
    logic signed [17:0] t_xl    [NUM_TESTS];
    logic signed [17:0] t_xr    [NUM_TESTS];
    logic signed [17:0] t_gain  [NUM_TESTS];
    int                 t_mode  [NUM_TESTS];
    logic signed [17:0] exp_l   [NUM_TESTS];
    logic signed [17:0] exp_r   [NUM_TESTS];
    int                 rank    [NUM_TESTS];
    int                 n_tests;

    int tq[$];
    int fq[$];
    int credits;
    int done_count;
    int passed;
    int failed;
    int errors;

    audio_alu_top i_audio_alu_top (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd_func    (i_cmd_func),
        .i_cmd_xl      (i_cmd_xl),
        .i_cmd_xr      (i_cmd_xr),
        .i_cmd_gain    (i_cmd_gain),
        .o_credit      (o_credit),
        .o_taylor_done (o_taylor_done),
        .o_taylor_l    (o_taylor_l),
        .o_taylor_r    (o_taylor_r),
        .o_fade_done   (o_fade_done),
        .o_fade_l      (o_fade_l),
        .o_fade_r      (o_fade_r)
    );

    always #10 i_clk = ~i_clk;

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    // series terms c_n in Q16, exp terms as held in the coefficient ROM
    function automatic logic signed [17:0] coef_of(input func_t f, input int n);
        logic signed [17:0] cos_c [8];
        logic signed [17:0] sin_c [8];
        logic signed [17:0] exp_c [8];
        cos_c = '{65536, 0, -32768, 0, 2731, 0, -91, 0};
        sin_c = '{0, 65536, 0, -10923, 0, 546, 0, -13};
        exp_c = '{108051, 108051, 54025, 18008, 4502, 900, 150, 21};
        if (f == FN_COS) return cos_c[n];
        else if (f == FN_SIN) return sin_c[n];
        else if (f == FN_EXP) return exp_c[n];
        else return '0;
    endfunction

    function automatic logic signed [17:0] point_of(input func_t f);
        return (f == FN_EXP) ? 18'sd32768 : 18'sd0;
    endfunction

    // a*b+c in 48 bits, cut back to bits 33..16
    function automatic logic signed [17:0] mul_add_cut(input logic signed [17:0] a,
                                                       input logic signed [17:0] b,
                                                       input logic signed [47:0] c);
        logic signed [47:0] wa;
        logic signed [47:0] wb;
        logic signed [47:0] p;
        wa = a;
        wb = b;
        p  = wa * wb + c;
        return p[33:16];
    endfunction

    function automatic logic signed [17:0] horner_ref(input func_t f,
                                                      input logic signed [17:0] x);
        logic signed [17:0] xa;
        logic signed [17:0] acc;
        logic signed [47:0] cw;
        xa  = x - point_of(f);
        acc = coef_of(f, 7);
        for (int n = 6; n >= 0; n--) begin
            cw  = coef_of(f, n);
            acc = mul_add_cut(acc, xa, cw <<< 16);
        end
        return acc;
    endfunction

    // own*g + other*(1-g), the second product kept at full width
    function automatic logic signed [17:0] blend_ref(input logic signed [17:0] own,
                                                     input logic signed [17:0] other,
                                                     input logic signed [17:0] g);
        logic signed [17:0] h;
        logic signed [47:0] wo;
        logic signed [47:0] wh;
        h  = `AU_ONE - g;
        wo = other;
        wh = h;
        return mul_add_cut(own, g, wo * wh);
    endfunction

    task automatic add_test(input string name, input func_t f, input int xl, input int xr,
                            input int g, input int mode);
        t_name[n_tests] = name;
        t_func[n_tests] = f;
        t_xl[n_tests]   = 18'(xl);
        t_xr[n_tests]   = 18'(xr);
        t_gain[n_tests] = 18'(g);
        t_mode[n_tests] = mode;
        rank[n_tests]   = -1;
        if (f == FN_FADE) begin
            exp_l[n_tests] = blend_ref(18'(xl), 18'(xr), 18'(g));
            exp_r[n_tests] = blend_ref(18'(xr), 18'(xl), 18'(g));
        end else begin
            exp_l[n_tests] = horner_ref(f, 18'(xl));
            exp_r[n_tests] = horner_ref(f, 18'(xr));
        end
        n_tests++;
    endtask

    task automatic load_table();
        n_tests = 0;
        add_test("cos_pos",     FN_COS,  16384,  32768,  0,     1);
        add_test("cos_neg",     FN_COS,  -16384, -52429, 0,     0);
        add_test("sin_pos",     FN_SIN,  19661,  45875,  0,     0);
        add_test("sin_neg",     FN_SIN,  -6554,  -39322, 0,     0);
        add_test("exp_pos",     FN_EXP,  13107,  39322,  0,     0);
        add_test("exp_neg",     FN_EXP,  -32768, -58982, 0,     0);
        add_test("fade_g0",     FN_FADE, 20000,  -30000, 0,     0);
        add_test("fade_g1",     FN_FADE, 20000,  -30000, 65536, 0);
        add_test("fade_half",   FN_FADE, 40000,  -12345, 32768, 0);
        add_test("taylor_head", FN_SIN,  26214,  -26214, 0,     1);
        add_test("fade_behind", FN_FADE, 11111,  22222,  16384, 2);
        add_test("cos_zero",    FN_COS,  0,      0,      0,     0);
        add_test("fade_neg",    FN_FADE, -50000, 60000,  49152, 0);
    endtask

    // --------------------------------------------------
    // result and credit monitor
    // --------------------------------------------------
    task automatic check_done(input bit is_fade, input logic signed [17:0] l,
                              input logic signed [17:0] r);
        int idx;
        if ((is_fade && fq.size() == 0) || (!is_fade && tq.size() == 0)) begin
            $display("%s calculator gave a done pulse with no command outstanding",
                     is_fade ? "crossfade" : "Taylor");
            errors++;
        end else begin
            idx = is_fade ? fq.pop_front() : tq.pop_front();
            rank[idx] = done_count;
            done_count++;
            if (l !== exp_l[idx] || r !== exp_r[idx]) begin
                $display("Error %s: expected l=%0d r=%0d, actual l=%0d r=%0d",
                         t_name[idx], exp_l[idx], exp_r[idx], l, r);
                failed++;
            end else begin
                $display("PASS %s l=%0d r=%0d", t_name[idx], l, r);
                passed++;
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (o_credit) begin
                if (credits >= `AU_QUEUE_DEPTH) begin
                    $display("credit returned while the host already held every credit");
                    errors++;
                end else begin
                    credits++;
                end
            end
            if (o_taylor_done) begin
                check_done(1'b0, o_taylor_l, o_taylor_r);
            end
            if (o_fade_done) begin
                check_done(1'b1, o_fade_l, o_fade_r);
            end
        end
    end

    task automatic send_cmd(input int idx);
        while (credits == 0) begin
            @(posedge i_clk);
            #1;
        end
        i_cmd_valid = 1'b1;
        i_cmd_func  = t_func[idx];
        i_cmd_xl    = t_xl[idx];
        i_cmd_xr    = t_xr[idx];
        i_cmd_gain  = t_gain[idx];
        credits--;
        if (t_func[idx] == FN_FADE) fq.push_back(idx);
        else tq.push_back(idx);
        @(posedge i_clk);
        #1;
        i_cmd_valid = 1'b0;
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int gap;
        int wait_cycles;
        int idx;
        bit quiet_bad;
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_func  = FN_COS;
        i_cmd_xl    = '0;
        i_cmd_xr    = '0;
        i_cmd_gain  = '0;
        credits     = `AU_QUEUE_DEPTH;
        done_count  = 0;
        passed      = 0;
        failed      = 0;
        errors      = 0;
        quiet_bad   = 1'b0;
        void'($urandom(32'ha054));
        load_table();
        repeat (4) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        // nothing may pulse before the first command
        repeat (5) begin
            @(negedge i_clk);
            if (o_credit || o_taylor_done || o_fade_done) quiet_bad = 1'b1;
        end
        if (quiet_bad) begin
            $display("Error reset_quiet: expected credit=0 done=0, actual pulse seen");
            failed++;
        end else begin
            $display("PASS reset_quiet");
            passed++;
        end
        @(posedge i_clk);
        #1;

        for (int i = 0; i < NUM_TESTS; i++) begin
            if (t_mode[i] == 1) begin
                while (tq.size() != 0 || fq.size() != 0) begin
                    @(posedge i_clk);
                    #1;
                end
            end else if (t_mode[i] == 0) begin
                gap = $urandom % 4;
                repeat (gap) begin
                    @(posedge i_clk);
                    #1;
                end
            end
            send_cmd(i);
        end

        wait_cycles = 0;
        while ((tq.size() + fq.size()) != 0 && wait_cycles < DRAIN_CYCLES) begin
            @(posedge i_clk);
            wait_cycles++;
        end
        while (tq.size() != 0) begin
            idx = tq.pop_front();
            $display("no result came back for test %s", t_name[idx]);
            errors++;
        end
        while (fq.size() != 0) begin
            idx = fq.pop_front();
            $display("no result came back for test %s", t_name[idx]);
            errors++;
        end

        // a crossfade sent right behind a Taylor command overtakes it
        for (int i = 1; i < NUM_TESTS; i++) begin
            if (t_mode[i] == 2 && t_func[i] == FN_FADE && t_func[i-1] != FN_FADE) begin
                if (rank[i] >= 0 && rank[i-1] >= 0 && rank[i] > rank[i-1]) begin
                    $display("crossfade %s finished after the Taylor command ahead of it",
                             t_name[i]);
                    errors++;
                end
            end
        end

        $display("%0d tests: %0d passed, %0d failed, %0d other errors",
                 NUM_TESTS + 1, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("watchdog expired after %0d cycles with results still outstanding",
                 WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

// File: audio_alu.f
+incdir+.
audio_alu_pkg.sv
cmd_queue.sv
dsp_arbiter.sv
dsp_mac.sv
taylor_coefs.sv
taylor_calc.sv
crossfade_calc.sv
audio_alu_top.sv
tb_audio_alu.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f audio_alu.f --top-module tb_audio_alu -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "^No errors$"; then
    exit 0
else
    exit 1
fi
